/* bg_subtract.f */
+incdir+testbench
verilog/video_pkg.sv
verilog/ctrl_pkg.sv
verilog/pixel_if.sv
verilog/cmd_decoder.sv
verilog/capture_sequencer.sv
verilog/line_delay.sv
verilog/display_mux.sv
verilog/bg_subtract_top.sv
testbench/tb_bg_subtract.sv

/* Bender.yml */
package:
  name: bg_subtract

sources:
  # packages first, then the interface and the design
  - verilog/video_pkg.sv
  - verilog/ctrl_pkg.sv
  - verilog/pixel_if.sv
  - verilog/cmd_decoder.sv
  - verilog/capture_sequencer.sv
  - verilog/line_delay.sv
  - verilog/display_mux.sv
  - verilog/bg_subtract_top.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_bg_subtract.sv

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ========================================
// reference state
// ========================================
logic        m_idle;        // decoder's first cycle out of reset
int          m_win_left;    // cycles left in the command window
disp_mode_e  m_mode;
logic        m_cap;
logic        m_recap;
seq_state_e  m_state;
int          m_start_cnt;
int          m_blink_cnt;
int          m_addr_rec;
int          m_addr_play;
logic        m_vs_r;
int          m_pre_cnt;
logic        m_shift;
logic [23:0] m_hist [HIST_LEN];  // [0] is the newest pixel
logic [7:0]  m_mem [int];        // bytes written during the recorded frame

function automatic logic [7:0] grey_of(input logic [23:0] p);
    int acc;
    acc = p[23:16] * 38 + p[15:8] * 75 + p[7:0] * 15;
    return acc[14:7];
endfunction

// power-up contents of the sram
function automatic logic [15:0] fill_word(input int a);
    return a[15:0] ^ {4{a[19:16]}} ^ 16'h3c5a;
endfunction

function automatic logic [7:0] mem_byte(input int a);
    logic [15:0] w;
    if (m_mem.exists(a)) return m_mem[a];
    w = fill_word(a);
    return w[7:0];
endfunction

task automatic compare_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, act, exp);
        test_err++;
    end
endtask

task automatic model_reset();
    m_idle      = 1'b1;
    m_win_left  = 0;
    m_mode      = mode_origin;
    m_cap       = 1'b0;
    m_recap     = 1'b0;
    m_state     = st_startup;
    m_start_cnt = 0;
    m_blink_cnt = 0;
    m_addr_rec  = 0;
    m_addr_play = 0;
    m_vs_r      = 1'b0;
    m_pre_cnt   = 0;
    m_shift     = 1'b0;
    foreach (m_hist[i]) m_hist[i] = '0;
    m_mem.delete();
endtask

// one clock edge of the whole path
task automatic model_step();
    logic [23:0] px;
    logic        vs_fall;
    logic        pre;
    int          lin;
    seq_state_e  nxt;
    disp_mode_e  mode_n;
    logic        cap_n;
    logic        recap_n;
    px      = {i_red[9:2], i_green[9:2], i_blue[9:2]};
    vs_fall = m_vs_r & ~i_vga_vsync;
    lin     = i_vga_request ? int'(i_vga_y) * LINE_W + int'(i_vga_x) : 0;
    pre     = (m_state == st_process) && (m_pre_cnt < LINE_W * PREF_L);
    if (m_state == st_record) m_mem[m_addr_rec] = grey_of(px);
    if (m_shift) begin
        for (int i = HIST_LEN - 1; i > 0; i--) m_hist[i] = m_hist[i-1];
        m_hist[0] = px;
    end
    m_shift = (m_state == st_process) && (pre || i_vga_request);
    if (pre) m_pre_cnt++;

    nxt = m_state;
    if (m_state != st_blink) m_blink_cnt = 0;
    case (m_state)
        st_startup: begin
            if (m_start_cnt == STARTUP_N) nxt = st_wait_capture;
            else m_start_cnt++;
        end
        st_wait_capture: if (m_cap) nxt = st_wait_frame;
        st_wait_frame: begin
            if (vs_fall) begin
                nxt        = st_record;
                m_addr_rec = 0;
            end
        end
        st_record: begin
            if (vs_fall) nxt = st_blink;
            else m_addr_rec = lin;
        end
        st_blink: begin
            if (m_blink_cnt > BLINK_N) begin
                if (vs_fall) nxt = st_process;
            end else begin
                m_blink_cnt++;
            end
        end
        default: begin
            m_addr_play = lin;
            if (m_recap) nxt = st_wait_capture;
        end
    endcase
    m_state = nxt;

    mode_n  = m_mode;
    cap_n   = 1'b0;
    recap_n = 1'b0;
    if (m_win_left > 0) begin
        if (i_control == cmd_grey) mode_n = mode_grey;
        else if (i_control == cmd_back) mode_n = mode_back;
        else if (i_control == cmd_capture) cap_n = 1'b1;
        else if (i_control == cmd_recapture) recap_n = 1'b1;
        else mode_n = mode_origin;
    end
    if (m_idle) m_idle = 1'b0;
    else if (m_win_left > 0) m_win_left--;
    else if (i_control_ready) m_win_left = 4;
    m_mode  = mode_n;
    m_cap   = cap_n;
    m_recap = recap_n;
    m_vs_r  = i_vga_vsync;
endtask

`endif

/* testbench/tb_bg_subtract.sv */
module tb_bg_subtract;
    import video_pkg::*;
    import ctrl_pkg::*;

    localparam int LINE_W     = 8;
    localparam int DELAY_D    = 5;
    localparam int PREF_L     = 2;
    localparam int STARTUP_N  = 20;
    localparam int BLINK_N    = 30;
    localparam int CLK_PERIOD = 8;
    localparam int FRAME_LEN  = 64;   // cycles from one vsync fall to the next
    localparam int HIST_LEN   = 3 * LINE_W + DELAY_D;
    // frame budget of each test in run order
    localparam int TOTAL_FRAMES = 2 + 2 + 3 + 2 + 6 + 4;
    localparam int WATCHDOG_T   = TOTAL_FRAMES * FRAME_LEN * CLK_PERIOD;

    logic        i_clk;
    logic        i_rst_n;
    logic [9:0]  i_red;
    logic [9:0]  i_green;
    logic [9:0]  i_blue;
    logic        i_control_ready;
    logic [7:0]  i_control;
    logic        i_vga_request;
    logic        i_vga_vsync;
    logic [12:0] i_vga_x;
    logic [12:0] i_vga_y;
    logic        o_sdram_read;
    logic [9:0]  o_red;
    logic [9:0]  o_green;
    logic [9:0]  o_blue;
    logic [19:0] o_sram_addr;
    wire  [15:0] io_sram_dq;
    logic        o_sram_we_n;
    logic        o_sram_ce_n;
    logic        o_sram_oe_n;
    logic        o_sram_lb_n;
    logic        o_sram_ub_n;

    integer      seed = 32'h36f95502;
    int          frame_pos;
    logic [7:0]  cur_code;
    int          test_err;
    int          total_err;
    int          tests_run;
    int          tests_failed;

    `include "tb_model.svh"

    bg_subtract_top #(
        .LINE_WIDTH     (LINE_W),
        .DELAY_DEPTH    (DELAY_D),
        .PREFETCH_LINES (PREF_L),
        .STARTUP_CYCLES (STARTUP_N),
        .BLINK_CYCLES   (BLINK_N)
    ) i_dut (.*);

    // ========================================
    // sram
    // ========================================
    logic [15:0] sram_mem [int];
    logic [15:0] sram_q;

    assign io_sram_dq = o_sram_we_n ? sram_q : 16'hzzzz;

    always @(posedge i_clk) begin
        if (o_sram_we_n === 1'b0) sram_mem[int'(o_sram_addr)] = {8'h00, io_sram_dq[7:0]};
    end

    always @(o_sram_addr or o_sram_we_n) begin
        if (sram_mem.exists(int'(o_sram_addr))) sram_q = sram_mem[int'(o_sram_addr)];
        else sram_q = fill_word(int'(o_sram_addr));
    end

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_T);
        $display("run stopped by the watchdog before all tests finished");
        $display("Test failed");
        $finish;
    end

    // ========================================
    // stimulus helpers
    // ========================================
    task automatic drive_inputs(input logic ready);
        int r;
        r = $random(seed);
        i_red   = r[9:0];
        i_green = r[19:10];
        i_blue  = r[29:20];
        r = $random(seed);
        i_vga_x         = 13'(r[2:0]);
        i_vga_y         = 13'(r[5:3]);
        i_vga_request   = (r[7:6] != 2'b00);  // high 3 cycles in 4
        i_vga_vsync     = (frame_pos >= 4);
        frame_pos       = (frame_pos + 1) % FRAME_LEN;
        i_control_ready = ready;
        i_control       = cur_code;
    endtask

    task automatic check_outputs();
        logic [23:0] d;
        logic [9:0]  er;
        logic [9:0]  eg;
        logic [9:0]  eb;
        logic        exp_read;
        int          addr;
        d        = m_hist[HIST_LEN-1];
        addr     = (m_state == st_record) ? m_addr_rec : m_addr_play;
        er       = i_red;
        eg       = i_green;
        eb       = i_blue;
        exp_read = i_vga_request;
        if (m_state == st_blink) begin
            er = 10'h3ff;
            eg = 10'h3ff;
            eb = 10'h3ff;
        end else if (m_state == st_process) begin
            exp_read = i_vga_request || (m_pre_cnt < LINE_W * PREF_L);
            if (m_mode == mode_grey) begin
                er = {2'b00, grey_of(d)};
                eg = er;
                eb = er;
            end else if (m_mode == mode_back) begin
                er = {2'b00, mem_byte(addr)};
                eg = er;
                eb = er;
            end else begin
                er = {d[23:16], 2'b00};
                eg = {d[15:8], 2'b00};
                eb = {d[7:0], 2'b00};
            end
        end
        compare_value("o_red", o_red, er);
        compare_value("o_green", o_green, eg);
        compare_value("o_blue", o_blue, eb);
        compare_value("o_sdram_read", o_sdram_read, exp_read);
        compare_value("o_sram_we_n", o_sram_we_n, m_state != st_record);
        compare_value("o_sram_addr", o_sram_addr, addr);
        compare_value("sram enables", {o_sram_ce_n, o_sram_oe_n, o_sram_lb_n, o_sram_ub_n}, 0);
        if (m_state == st_record)
            compare_value("io_sram_dq", io_sram_dq[7:0],
                          grey_of({i_red[9:2], i_green[9:2], i_blue[9:2]}));
    endtask

    task automatic run_cycle(input logic ready);
        @(negedge i_clk);
        check_outputs();
        drive_inputs(ready);
        @(posedge i_clk);
        model_step();
    endtask

    task automatic send_command(input logic [7:0] code);
        cur_code = code;
        run_cycle(1'b1);
        repeat (6) run_cycle(1'b0);  // code held through the window
    endtask

    function automatic logic [7:0] random_mode_code();
        int          r;
        logic [7:0] code;
        r = $random(seed);
        case (r[1:0])
            2'd0:    code = cmd_grey;
            2'd1:    code = cmd_back;
            2'd2:    code = cmd_origin;
            default: code = r[15:8];  // mostly unlisted
        endcase
        if (code == cmd_capture || code == cmd_recapture) code = code ^ 8'h01;
        return code;
    endfunction

    function automatic logic [7:0] random_unlisted_code();
        int r;
        r = $random(seed);
        return {1'b1, r[6:0]};  // listed codes all sit below 8'h80
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        test_err++;
    endtask

    task automatic run_until(input seq_state_e target, input int frames, input string what);
        int n;
        n = 0;
        while (m_state != target && n < frames * FRAME_LEN) begin
            run_cycle(1'b0);
            n++;
        end
        if (m_state != target) report_failure({what, " did not happen in time"});
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_err != 0) tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, test_err);
        total_err += test_err;
        test_err = 0;
    endtask

    task automatic apply_reset();
        model_reset();
        i_rst_n = 1'b0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(posedge i_clk);
        model_step();
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        i_rst_n         = 1'b0;
        i_red           = '0;
        i_green         = '0;
        i_blue          = '0;
        i_control_ready = 1'b0;
        i_control       = '0;
        i_vga_request   = 1'b0;
        i_vga_vsync     = 1'b0;
        i_vga_x         = '0;
        i_vga_y         = '0;
        frame_pos       = 0;
        cur_code        = 8'h00;
        test_err        = 0;
        total_err       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        apply_reset();

        repeat (FRAME_LEN) run_cycle(1'b0);
        if (m_state != st_wait_capture) report_failure("start-up wait never ended");
        finish_test("pass-through");

        repeat (6) send_command(random_mode_code());
        send_command(cmd_origin);
        send_command(cmd_capture);
        if (m_state != st_wait_frame) report_failure("capture code did not arm recording");
        finish_test("commands and capture");

        run_until(st_blink, 3, "end of recorded frame");
        finish_test("background record");

        run_until(st_process, 2, "end of blink");
        finish_test("white blink");

        repeat (FRAME_LEN) run_cycle(1'b0);  // covers the prefetch burst
        send_command(cmd_grey);
        repeat (FRAME_LEN / 2) run_cycle(1'b0);
        repeat (4) begin
            send_command(random_mode_code());
            repeat (FRAME_LEN / 2) run_cycle(1'b0);
        end
        send_command(cmd_back);
        repeat (FRAME_LEN / 4) run_cycle(1'b0);
        send_command(random_unlisted_code());  // unknown key falls back to origin
        repeat (FRAME_LEN / 4) run_cycle(1'b0);
        finish_test("delayed and grey image");

        send_command(cmd_back);
        repeat (2 * FRAME_LEN) run_cycle(1'b0);
        send_command(cmd_recapture);
        repeat (FRAME_LEN) run_cycle(1'b0);
        if (m_state != st_wait_capture) report_failure("recapture code was ignored");
        finish_test("playback and recapture");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_err);
        if (total_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/bg_subtract_top.sv */
module bg_subtract_top #(
    parameter int          LINE_WIDTH     = 800,
    parameter int          DELAY_DEPTH    = 5,
    parameter int          PREFETCH_LINES = 2,
    parameter int unsigned STARTUP_CYCLES = 32'h1ffffff,
    parameter int unsigned BLINK_CYCLES   = 32'h1312d00
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [video_pkg::pix_w-1:0]       i_red,
    input  logic [video_pkg::pix_w-1:0]       i_green,
    input  logic [video_pkg::pix_w-1:0]       i_blue,
    input  logic                              i_control_ready,
    input  logic [7:0]                        i_control,
    input  logic                              i_vga_request,
    input  logic                              i_vga_vsync,
    input  logic [video_pkg::coord_w-1:0]     i_vga_x,
    input  logic [video_pkg::coord_w-1:0]     i_vga_y,
    output logic                              o_sdram_read,
    output logic [video_pkg::pix_w-1:0]       o_red,
    output logic [video_pkg::pix_w-1:0]       o_green,
    output logic [video_pkg::pix_w-1:0]       o_blue,
    output logic [video_pkg::addr_w-1:0]      o_sram_addr,
    inout  wire  [15:0]                       io_sram_dq,
    output logic                              o_sram_we_n,
    output logic                              o_sram_ce_n,
    output logic                              o_sram_oe_n,
    output logic                              o_sram_lb_n,
    output logic                              o_sram_ub_n
);
    import video_pkg::*;
    import ctrl_pkg::*;

    rgb888_t    live_pix;
    grey_t      live_grey;
    seq_state_e state;
    disp_mode_e mode;
    logic       capture, recapture;
    logic       recording;

    pixel_if u_pix ();

    assign live_pix  = '{r: i_red[pix_w-1:2], g: i_green[pix_w-1:2], b: i_blue[pix_w-1:2]};
    assign live_grey = to_grey(live_pix);

    // ========================================
    // sram pins
    // ========================================
    assign io_sram_dq  = recording ? {8'h00, live_grey} : 16'hzzzz;
    assign o_sram_we_n = ~recording;
    assign o_sram_ce_n = 1'b0;
    assign o_sram_oe_n = 1'b0;
    assign o_sram_lb_n = 1'b0;
    assign o_sram_ub_n = 1'b0;

    cmd_decoder u_cmd_decoder (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_control_ready (i_control_ready),
        .i_control       (cmd_code_e'(i_control)),
        .o_mode          (mode),
        .o_capture       (capture),
        .o_recapture     (recapture)
    );

    capture_sequencer #(
        .LINE_WIDTH     (LINE_WIDTH),
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .BLINK_CYCLES   (BLINK_CYCLES)
    ) u_capture_sequencer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_capture     (capture),
        .i_recapture   (recapture),
        .i_vga_request (i_vga_request),
        .i_vga_vsync   (i_vga_vsync),
        .i_vga_x       (i_vga_x),
        .i_vga_y       (i_vga_y),
        .o_state       (state),
        .o_recording   (recording),
        .o_sram_addr   (o_sram_addr)
    );

    line_delay #(
        .LINE_WIDTH     (LINE_WIDTH),
        .DELAY_DEPTH    (DELAY_DEPTH),
        .PREFETCH_LINES (PREFETCH_LINES)
    ) u_line_delay (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_state       (state),
        .i_vga_request (i_vga_request),
        .i_pixel       (live_pix),
        .o_sdram_read  (o_sdram_read),
        .pix           (u_pix.src)
    );

    display_mux u_display_mux (
        .i_state     (state),
        .i_mode      (mode),
        .i_raw_red   (i_red),
        .i_raw_green (i_green),
        .i_raw_blue  (i_blue),
        .i_back_grey (io_sram_dq[7:0]),  // playback byte
        .pix         (u_pix.dst),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue)
    );

endmodule

/* verilog/display_mux.sv */
module display_mux (
    input  ctrl_pkg::seq_state_e              i_state,
    input  ctrl_pkg::disp_mode_e              i_mode,
    input  logic [video_pkg::pix_w-1:0]       i_raw_red,
    input  logic [video_pkg::pix_w-1:0]       i_raw_green,
    input  logic [video_pkg::pix_w-1:0]       i_raw_blue,
    input  video_pkg::grey_t                  i_back_grey,
    pixel_if.dst                              pix,
    output logic [video_pkg::pix_w-1:0]       o_red,
    output logic [video_pkg::pix_w-1:0]       o_green,
    output logic [video_pkg::pix_w-1:0]       o_blue
);
    import video_pkg::*;
    import ctrl_pkg::*;

    always_comb begin
        case (i_state)
            st_blink: begin  // white flash after capture
                o_red   = blink_level;
                o_green = blink_level;
                o_blue  = blink_level;
            end
            st_process: begin
                case (i_mode)
                    mode_grey: begin
                        o_red   = pix_w'(pix.grey);
                        o_green = pix_w'(pix.grey);
                        o_blue  = pix_w'(pix.grey);
                    end
                    mode_back: begin  // stored background from sram
                        o_red   = pix_w'(i_back_grey);
                        o_green = pix_w'(i_back_grey);
                        o_blue  = pix_w'(i_back_grey);
                    end
                    default: begin
                        o_red   = {pix.red, 2'b00};
                        o_green = {pix.green, 2'b00};
                        o_blue  = {pix.blue, 2'b00};
                    end
                endcase
            end
            default: begin  // camera straight through
                o_red   = i_raw_red;
                o_green = i_raw_green;
                o_blue  = i_raw_blue;
            end
        endcase
    end

endmodule

/* verilog/line_delay.sv */
module line_delay #(
    parameter int LINE_WIDTH     = 800,
    parameter int DELAY_DEPTH    = 5,
    parameter int PREFETCH_LINES = 2
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  ctrl_pkg::seq_state_e  i_state,
    input  logic                  i_vga_request,
    input  video_pkg::rgb888_t    i_pixel,
    output logic                  o_sdram_read,
    pixel_if.src                  pix
);
    import video_pkg::*;
    import ctrl_pkg::*;

    localparam int PREFETCH_NUM = LINE_WIDTH * PREFETCH_LINES;
    localparam int CNT_W        = $clog2(PREFETCH_NUM + 1);

    logic [CNT_W-1:0] prefetch_cnt;
    logic             prefetching;
    logic             shift_r, shift_w;

    rgb888_t line1 [LINE_WIDTH];
    rgb888_t line2 [LINE_WIDTH];
    rgb888_t line3 [LINE_WIDTH];
    rgb888_t delay_r [DELAY_DEPTH];

    // ========================================
    // prefetch and request
    // ========================================
    assign prefetching = (i_state == st_process) && (prefetch_cnt < PREFETCH_NUM);

    always_comb begin
        o_sdram_read = i_vga_request;
        shift_w      = 1'b0;
        if (i_state == st_process) begin
            o_sdram_read = prefetching | i_vga_request;
            shift_w      = prefetching | i_vga_request;  // data lands next cycle
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prefetch_cnt <= '0;
            shift_r      <= 1'b0;
        end else begin
            shift_r <= shift_w;
            if (prefetching) prefetch_cnt <= prefetch_cnt + 1'b1;
        end
    end

    // ========================================
    // three lines plus delay chain
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < LINE_WIDTH; i++) begin
                line1[i] <= '0;
                line2[i] <= '0;
                line3[i] <= '0;
            end
            for (int i = 0; i < DELAY_DEPTH; i++) begin
                delay_r[i] <= '0;
            end
        end else if (shift_r) begin
            line1[0]   <= i_pixel;
            line2[0]   <= line1[LINE_WIDTH-1];
            line3[0]   <= line2[LINE_WIDTH-1];
            delay_r[0] <= line3[LINE_WIDTH-1];
            for (int i = 1; i < LINE_WIDTH; i++) begin
                line1[i] <= line1[i-1];
                line2[i] <= line2[i-1];
                line3[i] <= line3[i-1];
            end
            for (int i = 1; i < DELAY_DEPTH; i++) begin
                delay_r[i] <= delay_r[i-1];
            end
        end
    end

    assign pix.red   = delay_r[DELAY_DEPTH-1].r;
    assign pix.green = delay_r[DELAY_DEPTH-1].g;
    assign pix.blue  = delay_r[DELAY_DEPTH-1].b;
    assign pix.grey  = to_grey(delay_r[DELAY_DEPTH-1]);

    a_prefetch_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        prefetch_cnt <= PREFETCH_NUM);

endmodule

/* verilog/capture_sequencer.sv */
module capture_sequencer #(
    parameter int          LINE_WIDTH     = 800,
    parameter int unsigned STARTUP_CYCLES = 32'h1ffffff,
    parameter int unsigned BLINK_CYCLES   = 32'h1312d00
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_capture,
    input  logic                              i_recapture,
    input  logic                              i_vga_request,
    input  logic                              i_vga_vsync,
    input  logic [video_pkg::coord_w-1:0]     i_vga_x,
    input  logic [video_pkg::coord_w-1:0]     i_vga_y,
    output ctrl_pkg::seq_state_e              o_state,
    output logic                              o_recording,
    output logic [video_pkg::addr_w-1:0]      o_sram_addr
);
    import video_pkg::*;
    import ctrl_pkg::*;

    seq_state_e        state_r, state_w;
    logic [31:0]       startup_cnt_r, startup_cnt_w;
    logic [31:0]       blink_cnt_r, blink_cnt_w;
    logic [addr_w-1:0] addr_rec_r, addr_rec_w;
    logic [addr_w-1:0] addr_play_r, addr_play_w;
    logic [addr_w-1:0] lin_addr;
    logic              vsync_r;
    logic              vs_fall;
    logic              recording_r;

    assign vs_fall  = vsync_r & ~i_vga_vsync;
    assign lin_addr = i_vga_request ? addr_w'(i_vga_y * LINE_WIDTH + i_vga_x) : '0;

    // ========================================
    // frame fsm
    // ========================================
    always_comb begin
        state_w       = state_r;
        startup_cnt_w = startup_cnt_r;
        blink_cnt_w   = '0;
        addr_rec_w    = addr_rec_r;
        addr_play_w   = addr_play_r;
        case (state_r)
            st_startup: begin
                if (startup_cnt_r == STARTUP_CYCLES) state_w = st_wait_capture;
                else startup_cnt_w = startup_cnt_r + 32'd1;
            end
            st_wait_capture: begin
                if (i_capture) state_w = st_wait_frame;
            end
            st_wait_frame: begin
                if (vs_fall) begin
                    state_w    = st_record;
                    addr_rec_w = '0;
                end
            end
            st_record: begin  // one full frame into sram
                if (vs_fall) state_w    = st_blink;
                else         addr_rec_w = lin_addr;
            end
            st_blink: begin
                blink_cnt_w = blink_cnt_r;
                if (blink_cnt_r > BLINK_CYCLES) begin
                    if (vs_fall) state_w = st_process;
                end else begin
                    blink_cnt_w = blink_cnt_r + 32'd1;
                end
            end
            st_process: begin
                addr_play_w = lin_addr;
                if (i_recapture) state_w = st_wait_capture;
            end
            default: state_w = st_startup;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r       <= st_startup;
            startup_cnt_r <= '0;
            blink_cnt_r   <= '0;
            addr_rec_r    <= '0;
            addr_play_r   <= '0;
            vsync_r       <= 1'b0;
            recording_r   <= 1'b0;
        end else begin
            state_r       <= state_w;
            startup_cnt_r <= startup_cnt_w;
            blink_cnt_r   <= blink_cnt_w;
            addr_rec_r    <= addr_rec_w;
            addr_play_r   <= addr_play_w;
            vsync_r       <= i_vga_vsync;
            recording_r   <= (state_w == st_record);  // tracks next state
        end
    end

    assign o_state     = state_r;
    assign o_recording = recording_r;
    assign o_sram_addr = (state_r == st_record) ? addr_rec_r : addr_play_r;

    a_rec_in_record: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_recording == (o_state == st_record));

endmodule

/* verilog/cmd_decoder.sv */
module cmd_decoder (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_control_ready,
    input  ctrl_pkg::cmd_code_e    i_control,
    output ctrl_pkg::disp_mode_e   o_mode,
    output logic                   o_capture,
    output logic                   o_recapture
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        dec_idle,
        dec_wait,
        dec_output
    } dec_state_e;

    dec_state_e state_r, state_w;
    logic [1:0] cnt_r, cnt_w;
    disp_mode_e mode_r, mode_w;
    logic       capture_w, recapture_w;

    // command window, 4 cycles after ready
    always_comb begin
        state_w = state_r;
        cnt_w   = cnt_r;
        case (state_r)
            dec_idle: state_w = dec_wait;
            dec_wait: begin
                cnt_w = '0;
                if (i_control_ready) state_w = dec_output;
            end
            dec_output: begin
                if (cnt_r == 2'd3) state_w = dec_wait;
                else               cnt_w   = cnt_r + 2'd1;
            end
            default: state_w = dec_idle;
        endcase
    end

    always_comb begin
        mode_w      = mode_r;
        capture_w   = 1'b0;
        recapture_w = 1'b0;
        if (state_r == dec_output) begin
            case (i_control)
                cmd_origin:    mode_w      = mode_origin;
                cmd_grey:      mode_w      = mode_grey;
                cmd_back:      mode_w      = mode_back;
                cmd_capture:   capture_w   = 1'b1;
                cmd_recapture: recapture_w = 1'b1;
                default:       mode_w      = mode_origin;  // unknown key
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= dec_idle;
            cnt_r       <= '0;
            mode_r      <= mode_origin;
            o_capture   <= 1'b0;
            o_recapture <= 1'b0;
        end else begin
            state_r     <= state_w;
            cnt_r       <= cnt_w;
            mode_r      <= mode_w;
            o_capture   <= capture_w;
            o_recapture <= recapture_w;
        end
    end

    assign o_mode = mode_r;

    a_one_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_capture && o_recapture));

endmodule

/* verilog/pixel_if.sv */
interface pixel_if;
    import video_pkg::*;

    // delayed pixel, 8 bits per channel
    chan8_t red;
    chan8_t green;
    chan8_t blue;
    grey_t  grey;   // grey of the same pixel

    modport src (
        output red, green, blue, grey
    );

    modport dst (
        input red, green, blue, grey
    );

endinterface

/* verilog/ctrl_pkg.sv */
package ctrl_pkg;

    // frame level phases of the capture path
    typedef enum logic [2:0] {
        st_startup,
        st_wait_capture,
        st_wait_frame,
        st_record,
        st_blink,
        st_process
    } seq_state_e;

    // what the display shows while processing
    typedef enum logic [1:0] {
        mode_origin,
        mode_grey,
        mode_back
    } disp_mode_e;

    // ========================================
    // remote control codes
    // ========================================
    typedef enum logic [7:0] {
        cmd_grey      = 8'h02,
        cmd_back      = 8'h03,
        cmd_origin    = 8'h10,
        cmd_capture   = 8'h12,
        cmd_recapture = 8'h16
    } cmd_code_e;

    // anything else on the remote decodes as origin

endpackage

/* verilog/video_pkg.sv */
package video_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int pix_w   = 10;    // camera channel
    localparam int coord_w = 13;    // vga x / y
    localparam int addr_w  = 20;    // sram word address

    typedef logic [7:0] chan8_t;
    typedef logic [7:0] grey_t;

    typedef struct packed {
        chan8_t r;
        chan8_t g;
        chan8_t b;
    } rgb888_t;

    // ========================================
    // grey conversion
    // ========================================
    localparam int grey_wr    = 38;
    localparam int grey_wg    = 75;
    localparam int grey_wb    = 15;
    localparam int grey_shift = 7;  // weights sum to 128

    localparam logic [pix_w-1:0] blink_level = '1;

    function automatic grey_t to_grey(rgb888_t p);
        logic [15:0] acc;
        acc = 16'(p.r) * 16'(grey_wr)
            + 16'(p.g) * 16'(grey_wg)
            + 16'(p.b) * 16'(grey_wb);
        return grey_t'(acc >> grey_shift);
    endfunction

endpackage
